//--- logic/boardman_pkg.sv
package boardman_pkg;

    // stream and bus widths
    localparam int byte_w    = 8;
    localparam int data_w    = 32;
    localparam int lanes     = 4;
    localparam int hdr_w     = 24;
    localparam int bus_adr_w = 20;

    // bit positions in the msb-first command header
    localparam int wr_bit   = 23;
    localparam int hold_bit = 22;

    typedef logic [1:0] lane_t;

    typedef enum logic [4:0] {
        idle,
        hdr2,
        hdr1,
        hdr0,
        rd_len,
        rd_hdr2,
        rd_hdr1,
        rd_hdr0,
        rd_fetch,
        rd_data,
        wr_fill,
        wr_issue,
        wr_hdr2,
        wr_hdr1,
        wr_hdr0,
        wr_count
    } seq_state_t;

endpackage

//--- logic/boardman_seq.sv
module boardman_seq (
    input  logic                     clk,
    input  logic                     rst_i,
    input  logic                     rx_valid_i,
    input  logic                     rx_last_i,
    input  logic                     rx_user_i,
    input  logic                     tx_ready_i,
    input  logic                     bus_ack_i,
    input  logic                     wr_cmd_i,
    input  boardman_pkg::lane_t      start_lane_i,
    input  logic                     strobe_full_i,
    input  logic                     last_taken_i,
    input  logic                     count_zero_i,
    output boardman_pkg::seq_state_t state_o,
    output boardman_pkg::lane_t      lane_o,
    output logic                     rx_ready_o,
    output logic                     tx_valid_o,
    output logic                     bus_en_o,
    output logic                     bus_wr_o
);
    import boardman_pkg::*;

    seq_state_t state_q;
    seq_state_t state_d;
    lane_t      lane_q;
    logic       rx_end;

    // last or user on a header byte means the command is cut short
    assign rx_end = rx_last_i || rx_user_i;

    always_comb begin
        state_d = state_q;
        case (state_q)
            idle: begin
                // stray bytes with last or user are drained here
                if (rx_valid_i && !rx_end) begin
                    state_d = hdr2;
                end
            end
            hdr2: begin
                if (rx_valid_i) begin
                    state_d = rx_end ? idle : hdr1;
                end
            end
            hdr1: begin
                if (rx_valid_i) begin
                    state_d = rx_end ? idle : hdr0;
                end
            end
            hdr0: begin
                if (rx_valid_i) begin
                    if (rx_end) begin
                        state_d = idle;
                    end else begin
                        state_d = wr_cmd_i ? wr_fill : rd_len;
                    end
                end
            end
            rd_len: begin
                // length byte must close the command
                if (rx_valid_i) begin
                    state_d = (rx_user_i || !rx_last_i) ? idle : rd_hdr2;
                end
            end
            rd_hdr2: state_d = tx_ready_i ? rd_hdr1 : rd_hdr2;
            rd_hdr1: state_d = tx_ready_i ? rd_hdr0 : rd_hdr1;
            rd_hdr0: state_d = tx_ready_i ? rd_fetch : rd_hdr0;
            rd_fetch: begin
                if (bus_ack_i) begin
                    state_d = rd_data;
                end
            end
            rd_data: begin
                if (tx_ready_i) begin
                    if (count_zero_i) begin
                        state_d = idle;
                    end else if (lane_q == lane_t'(lanes - 1)) begin
                        state_d = rd_fetch;
                    end
                end
            end
            wr_fill: begin
                if (rx_valid_i) begin
                    if (rx_user_i) begin
                        state_d = idle;
                    end else if (rx_last_i || strobe_full_i) begin
                        state_d = wr_issue;
                    end
                end
            end
            wr_issue: begin
                if (bus_ack_i) begin
                    state_d = last_taken_i ? wr_hdr2 : wr_fill;
                end
            end
            wr_hdr2: state_d = tx_ready_i ? wr_hdr1 : wr_hdr2;
            wr_hdr1: state_d = tx_ready_i ? wr_hdr0 : wr_hdr1;
            wr_hdr0: state_d = tx_ready_i ? wr_count : wr_hdr0;
            wr_count: state_d = tx_ready_i ? idle : wr_count;
            default: state_d = idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            state_q <= idle;
            lane_q  <= '0;
        end else begin
            state_q <= state_d;
            // lane wraps from 3 back to 0 on its own
            if (state_q == hdr0 && rx_valid_i) begin
                lane_q <= start_lane_i;
            end else if (state_q == wr_fill && rx_valid_i && !rx_user_i) begin
                lane_q <= lane_q + lane_t'(1);
            end else if (state_q == rd_data && tx_ready_i) begin
                lane_q <= lane_q + lane_t'(1);
            end
        end
    end

    assign state_o    = state_q;
    assign lane_o     = lane_q;
    assign rx_ready_o = (state_q inside {hdr2, hdr1, hdr0, rd_len, wr_fill}) ||
                        (state_q == idle && rx_valid_i && rx_end);
    assign tx_valid_o = state_q inside {rd_hdr2, rd_hdr1, rd_hdr0, rd_data,
                                        wr_hdr2, wr_hdr1, wr_hdr0, wr_count};
    assign bus_en_o   = (state_q == rd_fetch) || (state_q == wr_issue);
    assign bus_wr_o   = (state_q == wr_issue);

endmodule

//--- logic/boardman_addr_track.sv
module boardman_addr_track (
    input  logic                                   clk,
    input  logic                                   rst_i,
    input  boardman_pkg::seq_state_t               state_i,
    input  boardman_pkg::lane_t                    lane_i,
    input  logic [boardman_pkg::byte_w-1:0]        rx_data_i,
    input  logic                                   rx_valid_i,
    input  logic                                   tx_ready_i,
    input  logic                                   bus_ack_i,
    output logic [boardman_pkg::hdr_w-1:0]         header_o,
    output logic                                   wr_cmd_o,
    output boardman_pkg::lane_t                    start_lane_o,
    output logic [boardman_pkg::bus_adr_w-1:0]     bus_adr_o,
    output logic [boardman_pkg::byte_w-1:0]        count_o,
    output logic                                   count_zero_o
);
    import boardman_pkg::*;

    logic [hdr_w-1:0]     header_q;
    logic [bus_adr_w-1:0] adr_q;
    logic [byte_w-1:0]    count_q;
    logic                 adr_step;

    always_ff @(posedge clk) begin
        if (rx_valid_i) begin
            case (state_i)
                hdr2: header_q[hdr_w-1 -: byte_w] <= rx_data_i;
                hdr1: header_q[2*byte_w-1 -: byte_w] <= rx_data_i;
                hdr0: header_q[byte_w-1:0] <= rx_data_i;
                default: header_q <= header_q;
            endcase
        end
    end

    // a write only steps once its word wrapped past the top lane
    assign adr_step = bus_ack_i && !header_q[hold_bit] &&
                      (state_i == rd_fetch || (state_i == wr_issue && lane_i == '0));

    always_ff @(posedge clk) begin
        if (state_i == hdr0 && rx_valid_i) begin
            adr_q <= {header_q[hold_bit-1:byte_w], rx_data_i[byte_w-1:2]};
        end else if (adr_step) begin
            adr_q <= adr_q + bus_adr_w'(1);
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i || state_i == idle) begin
            count_q <= '0;
        end else if (state_i == wr_fill && rx_valid_i) begin
            count_q <= count_q + byte_w'(1);
        end else if (state_i == rd_len && rx_valid_i) begin
            count_q <= rx_data_i;
        end else if (state_i == rd_data && tx_ready_i) begin
            count_q <= count_q - byte_w'(1);
        end
    end

    // low header byte is still on the stream during hdr0
    assign start_lane_o = (state_i == hdr0) ? rx_data_i[1:0] : header_q[1:0];
    assign header_o     = header_q;
    assign wr_cmd_o     = header_q[wr_bit];
    assign bus_adr_o    = adr_q;
    assign count_o      = count_q;
    assign count_zero_o = (count_q == '0);

endmodule

//--- logic/boardman_word_buf.sv
module boardman_word_buf (
    input  logic                                clk,
    input  logic                                rst_i,
    input  boardman_pkg::seq_state_t            state_i,
    input  boardman_pkg::lane_t                 lane_i,
    input  logic [boardman_pkg::byte_w-1:0]     rx_data_i,
    input  logic                                rx_valid_i,
    input  logic                                rx_last_i,
    input  logic                                bus_ack_i,
    input  logic [boardman_pkg::data_w-1:0]     bus_dat_i,
    output logic [boardman_pkg::data_w-1:0]     bus_dat_o,
    output logic [boardman_pkg::lanes-1:0]      bus_wstrb_o,
    output logic                                strobe_full_o,
    output logic                                last_taken_o,
    output logic [boardman_pkg::byte_w-1:0]     lane_byte_o
);
    import boardman_pkg::*;

    logic [data_w-1:0] data_q;
    logic [lanes-1:0]  wstrb_q;
    logic [lanes-1:0]  fill_strb;
    logic              last_taken_q;
    logic              fill;
    lane_t             sel_lane;
    logic [data_w-1:0] src_word;

    assign fill      = (state_i == wr_fill) && rx_valid_i;
    assign fill_strb = wstrb_q | (lanes'(1) << lane_i);

    always_ff @(posedge clk) begin
        if (fill) begin
            data_q[lane_i*byte_w +: byte_w] <= rx_data_i;
        end else if (state_i == rd_fetch && bus_ack_i) begin
            data_q <= bus_dat_i;
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i || state_i == idle || (state_i == wr_issue && bus_ack_i)) begin
            wstrb_q <= '0;
        end else if (fill) begin
            wstrb_q <= fill_strb;
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i || state_i == idle) begin
            last_taken_q <= 1'b0;
        end else if (fill) begin
            last_taken_q <= rx_last_i;
        end
    end

    // lanes fill upward, so the top strobe means the word is done
    assign strobe_full_o = fill_strb[lanes-1];

    // the response byte is picked one step ahead of the send
    assign sel_lane    = (state_i == rd_data) ? lane_i + lane_t'(1) : lane_i;
    assign src_word    = (state_i == rd_fetch) ? bus_dat_i : data_q;
    assign lane_byte_o = src_word[sel_lane*byte_w +: byte_w];

    assign bus_dat_o    = data_q;
    assign bus_wstrb_o  = wstrb_q;
    assign last_taken_o = last_taken_q;

endmodule

//--- logic/boardman_tx_mux.sv
module boardman_tx_mux (
    input  logic                                clk,
    input  logic                                rst_i,
    input  boardman_pkg::seq_state_t            state_i,
    input  logic                                tx_ready_i,
    input  logic [boardman_pkg::hdr_w-1:0]      header_i,
    input  logic [boardman_pkg::byte_w-1:0]     count_i,
    input  logic                                count_zero_i,
    input  logic [boardman_pkg::byte_w-1:0]     lane_byte_i,
    output logic [boardman_pkg::byte_w-1:0]     tx_data_o,
    output logic                                tx_last_o
);
    import boardman_pkg::*;

    logic [byte_w-1:0] tx_data_q;
    logic              tx_last_q;
    logic              load;
    logic [byte_w-1:0] nxt_data;
    logic              nxt_last;

    // next byte is ready before the state that sends it
    always_comb begin
        load     = 1'b0;
        nxt_data = tx_data_q;
        nxt_last = 1'b0;
        case (state_i)
            rd_len, wr_issue: begin
                load     = 1'b1;
                nxt_data = header_i[hdr_w-1 -: byte_w];
            end
            rd_hdr2, wr_hdr2: begin
                load     = tx_ready_i;
                nxt_data = header_i[2*byte_w-1 -: byte_w];
            end
            rd_hdr1, wr_hdr1: begin
                load     = tx_ready_i;
                nxt_data = header_i[byte_w-1:0];
            end
            rd_fetch: begin
                // keeps loading until the ack cycle leaves the state
                load     = 1'b1;
                nxt_data = lane_byte_i;
                nxt_last = count_zero_i;
            end
            rd_data: begin
                load     = tx_ready_i;
                nxt_data = lane_byte_i;
                nxt_last = (count_i == byte_w'(1));
            end
            wr_hdr0: begin
                load     = tx_ready_i;
                nxt_data = count_i;
                nxt_last = 1'b1;
            end
            default: load = 1'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (load) begin
            tx_data_q <= nxt_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            tx_last_q <= 1'b0;
        end else if (load) begin
            tx_last_q <= nxt_last;
        end
    end

    assign tx_data_o = tx_data_q;
    assign tx_last_o = tx_last_q;

endmodule

//--- logic/boardman_core.sv
module boardman_core (
    input  logic                                  clk,
    input  logic                                  rst_i,
    input  logic [boardman_pkg::byte_w-1:0]       rx_data_i,
    input  logic                                  rx_valid_i,
    input  logic                                  rx_last_i,
    input  logic                                  rx_user_i,
    output logic                                  rx_ready_o,
    output logic [boardman_pkg::byte_w-1:0]       tx_data_o,
    output logic                                  tx_valid_o,
    output logic                                  tx_last_o,
    input  logic                                  tx_ready_i,
    output logic [boardman_pkg::bus_adr_w-1:0]    bus_adr_o,
    output logic [boardman_pkg::data_w-1:0]       bus_dat_o,
    output logic                                  bus_en_o,
    output logic                                  bus_wr_o,
    output logic [boardman_pkg::lanes-1:0]        bus_wstrb_o,
    input  logic [boardman_pkg::data_w-1:0]       bus_dat_i,
    input  logic                                  bus_ack_i
);
    import boardman_pkg::*;

    seq_state_t        state;
    lane_t             lane;
    lane_t             start_lane;
    logic              wr_cmd;
    logic              strobe_full;
    logic              last_taken;
    logic              count_zero;
    logic [hdr_w-1:0]  header;
    logic [byte_w-1:0] count;
    logic [byte_w-1:0] lane_byte;

    boardman_seq i_seq (
        .clk          (clk),
        .rst_i        (rst_i),
        .rx_valid_i   (rx_valid_i),
        .rx_last_i    (rx_last_i),
        .rx_user_i    (rx_user_i),
        .tx_ready_i   (tx_ready_i),
        .bus_ack_i    (bus_ack_i),
        .wr_cmd_i     (wr_cmd),
        .start_lane_i (start_lane),
        .strobe_full_i(strobe_full),
        .last_taken_i (last_taken),
        .count_zero_i (count_zero),
        .state_o      (state),
        .lane_o       (lane),
        .rx_ready_o   (rx_ready_o),
        .tx_valid_o   (tx_valid_o),
        .bus_en_o     (bus_en_o),
        .bus_wr_o     (bus_wr_o)
    );

    boardman_addr_track i_addr_track (
        .clk          (clk),
        .rst_i        (rst_i),
        .state_i      (state),
        .lane_i       (lane),
        .rx_data_i    (rx_data_i),
        .rx_valid_i   (rx_valid_i),
        .tx_ready_i   (tx_ready_i),
        .bus_ack_i    (bus_ack_i),
        .header_o     (header),
        .wr_cmd_o     (wr_cmd),
        .start_lane_o (start_lane),
        .bus_adr_o    (bus_adr_o),
        .count_o      (count),
        .count_zero_o (count_zero)
    );

    boardman_word_buf i_word_buf (
        .clk          (clk),
        .rst_i        (rst_i),
        .state_i      (state),
        .lane_i       (lane),
        .rx_data_i    (rx_data_i),
        .rx_valid_i   (rx_valid_i),
        .rx_last_i    (rx_last_i),
        .bus_ack_i    (bus_ack_i),
        .bus_dat_i    (bus_dat_i),
        .bus_dat_o    (bus_dat_o),
        .bus_wstrb_o  (bus_wstrb_o),
        .strobe_full_o(strobe_full),
        .last_taken_o (last_taken),
        .lane_byte_o  (lane_byte)
    );

    boardman_tx_mux i_tx_mux (
        .clk          (clk),
        .rst_i        (rst_i),
        .state_i      (state),
        .tx_ready_i   (tx_ready_i),
        .header_i     (header),
        .count_i      (count),
        .count_zero_i (count_zero),
        .lane_byte_i  (lane_byte),
        .tx_data_o    (tx_data_o),
        .tx_last_o    (tx_last_o)
    );

endmodule

//--- sim/tb_reg_target.sv
module tb_reg_target (
    input  logic                                clk,
    input  logic                                rst_i,
    input  logic                                en_i,
    input  logic                                wr_i,
    input  logic [boardman_pkg::bus_adr_w-1:0]  adr_i,
    input  logic [boardman_pkg::data_w-1:0]     dat_i,
    input  logic [boardman_pkg::lanes-1:0]      wstrb_i,
    output logic [boardman_pkg::data_w-1:0]     dat_o,
    output logic                                ack_o
);
    timeunit 1ns;
    timeprecision 1ps;
    import boardman_pkg::*;

    localparam int depth = 1024;

    logic [data_w-1:0] mem [depth];
    logic [1:0]        wait_cnt;
    logic [1:0]        delay_q;
    integer            seed = 32'h58ce;
    integer            rnd;
    integer            idx;
    integer            l;

    // ack once enable has been up for delay_q cycles
    // a zero delay acks in the first cycle of the access
    assign ack_o = en_i && (wait_cnt == delay_q);
    assign dat_o = mem[adr_i[9:0]];

    always @(posedge clk) begin
        if (rst_i) begin
            for (idx = 0; idx < depth; idx++) begin
                mem[idx] <= '0;
            end
            wait_cnt <= '0;
            delay_q  <= '0;
        end else if (ack_o) begin
            if (wr_i) begin
                for (l = 0; l < lanes; l++) begin
                    if (wstrb_i[l]) begin
                        mem[adr_i[9:0]][l*byte_w +: byte_w] <= dat_i[l*byte_w +: byte_w];
                    end
                end
            end
            // delay for the next access is drawn here
            rnd = $random(seed);
            delay_q  <= rnd[1:0];
            wait_cnt <= '0;
        end else if (en_i) begin
            wait_cnt <= wait_cnt + 2'd1;
        end
    end

endmodule

//--- sim/boardman_assert.sv
module boardman_assert (
    input  logic                                clk,
    input  logic                                rst_i,
    input  logic                                bus_en_i,
    input  logic                                bus_wr_i,
    input  logic [boardman_pkg::bus_adr_w-1:0]  bus_adr_i,
    input  logic [boardman_pkg::lanes-1:0]      bus_wstrb_i,
    input  logic                                bus_ack_i,
    input  logic                                tx_valid_i,
    input  logic                                tx_ready_i,
    input  logic [boardman_pkg::byte_w-1:0]     tx_data_i,
    input  logic                                tx_last_i
);
    timeunit 1ns;
    timeprecision 1ps;

    int fail_cnt = 0;

    // a bus request stays put until the target acks it
    bus_hold: assert property (@(posedge clk) disable iff (rst_i)
        bus_en_i && !bus_ack_i |=> bus_en_i && $stable(bus_adr_i) && $stable(bus_wr_i))
    else begin
        $error("bus enable or address changed before ack");
        fail_cnt++;
    end

    wstrb_set: assert property (@(posedge clk) disable iff (rst_i)
        bus_en_i && bus_wr_i |-> bus_wstrb_i != '0)
    else begin
        $error("bus write issued with an empty strobe");
        fail_cnt++;
    end

    // stalled response byte must not move
    tx_hold: assert property (@(posedge clk) disable iff (rst_i)
        tx_valid_i && !tx_ready_i |=> tx_valid_i && $stable(tx_data_i) && $stable(tx_last_i))
    else begin
        $error("tx byte changed while stalled");
        fail_cnt++;
    end

endmodule

bind boardman_core boardman_assert i_boardman_assert (
    .clk         (clk),
    .rst_i       (rst_i),
    .bus_en_i    (bus_en_o),
    .bus_wr_i    (bus_wr_o),
    .bus_adr_i   (bus_adr_o),
    .bus_wstrb_i (bus_wstrb_o),
    .bus_ack_i   (bus_ack_i),
    .tx_valid_i  (tx_valid_o),
    .tx_ready_i  (tx_ready_i),
    .tx_data_i   (tx_data_o),
    .tx_last_i   (tx_last_o)
);

//--- sim/tb_boardman.sv
module tb_boardman;
    timeunit 1ns;
    timeprecision 1ps;
    import boardman_pkg::*;

    localparam int max_rec = 32;
    localparam int max_in  = 256;
    localparam int max_exp = 512;

    logic                 clk = 1'b0;
    logic                 rst_i;
    logic [byte_w-1:0]    rx_data_i;
    logic                 rx_valid_i;
    logic                 rx_last_i;
    logic                 rx_user_i;
    logic                 rx_ready_o;
    logic [byte_w-1:0]    tx_data_o;
    logic                 tx_valid_o;
    logic                 tx_last_o;
    logic                 tx_ready_i = 1'b0;
    logic [bus_adr_w-1:0] bus_adr_o;
    logic [data_w-1:0]    bus_dat_o;
    logic                 bus_en_o;
    logic                 bus_wr_o;
    logic [lanes-1:0]     bus_wstrb_o;
    logic [data_w-1:0]    bus_dat_i;
    logic                 bus_ack_i;

    integer seed = 32'h58ce;
    integer rnd;
    integer cycle_cnt = 0;
    integer timeout_limit = 0;
    integer r;

    // parsed test records with their bytes in flat arrays
    logic [7:0]           rec_kind [max_rec];
    logic [hdr_w-1:0]     rec_hdr [max_rec];
    integer               rec_n_in [max_rec];
    integer               rec_in_ofs [max_rec];
    integer               rec_n_exp [max_rec];
    integer               rec_exp_ofs [max_rec];
    logic [11:0]          in_words [max_in];
    logic [byte_w-1:0]    exp_bytes [max_exp];
    integer               n_rec = 0;
    integer               in_total = 0;
    integer               exp_total = 0;
    logic [byte_w:0]      rsp_q [$];

    boardman_core i_boardman_core (
        .clk         (clk),
        .rst_i       (rst_i),
        .rx_data_i   (rx_data_i),
        .rx_valid_i  (rx_valid_i),
        .rx_last_i   (rx_last_i),
        .rx_user_i   (rx_user_i),
        .rx_ready_o  (rx_ready_o),
        .tx_data_o   (tx_data_o),
        .tx_valid_o  (tx_valid_o),
        .tx_last_o   (tx_last_o),
        .tx_ready_i  (tx_ready_i),
        .bus_adr_o   (bus_adr_o),
        .bus_dat_o   (bus_dat_o),
        .bus_en_o    (bus_en_o),
        .bus_wr_o    (bus_wr_o),
        .bus_wstrb_o (bus_wstrb_o),
        .bus_dat_i   (bus_dat_i),
        .bus_ack_i   (bus_ack_i)
    );

    tb_reg_target i_reg_target (
        .clk     (clk),
        .rst_i   (rst_i),
        .en_i    (bus_en_o),
        .wr_i    (bus_wr_o),
        .adr_i   (bus_adr_o),
        .dat_i   (bus_dat_o),
        .wstrb_i (bus_wstrb_o),
        .dat_o   (bus_dat_i),
        .ack_o   (bus_ack_i)
    );

    always #10 clk = ~clk;

    // response sink stalls at random about one cycle in four
    always @(negedge clk) begin
        rnd = $random(seed);
        tx_ready_i = (rnd[1:0] != 2'b00);
    end

    always @(posedge clk) begin
        if (!rst_i && tx_valid_o && tx_ready_i) begin
            rsp_q.push_back({tx_last_o, tx_data_o});
        end
    end

    task automatic stop_with_failure();
        $display("Test failures found");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("** Error at %0t: %s is %h, expected %h", $time, name, got, exp);
            stop_with_failure();
        end
    endtask

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt > timeout_limit) begin
            $display("timeout: the DUT made no full progress within %0d cycles", cycle_cnt);
            stop_with_failure();
        end
    end

    always @(negedge clk) begin
        if (i_boardman_core.i_boardman_assert.fail_cnt != 0) begin
            $display("a bus or stream protocol assertion failed");
            stop_with_failure();
        end
    end

    task automatic load_testdata();
        integer           fd;
        integer           code;
        integer           k;
        integer           n_in;
        integer           n_exp;
        logic [7:0]       kind;
        logic [hdr_w-1:0] hdr;
        logic [11:0]      word_in;
        logic [7:0]       byte_exp;
        logic [8*128-1:0] line;
        logic             done;
        fd = $fopen("sim/boardman_testdata.txt", "r");
        if (fd == 0) begin
            $display("cannot open the test data file sim/boardman_testdata.txt");
            stop_with_failure();
        end
        done = 1'b0;
        while (!done) begin
            code = $fscanf(fd, " %c", kind);
            if (code != 1) begin
                done = 1'b1;
            end else if (kind == "#") begin
                code = $fgets(line, fd);
            end else begin
                code = $fscanf(fd, "%h %d", hdr, n_in);
                if (code != 2 || !(kind inside {"W", "R", "A"}) || n_rec >= max_rec ||
                    in_total + n_in > max_in) begin
                    $display("test data record %0d is malformed or does not fit", n_rec);
                    stop_with_failure();
                end
                rec_kind[n_rec]   = kind;
                rec_hdr[n_rec]    = hdr;
                rec_n_in[n_rec]   = n_in;
                rec_in_ofs[n_rec] = in_total;
                for (k = 0; k < n_in; k++) begin
                    code = $fscanf(fd, "%h", word_in);
                    in_words[in_total] = word_in;
                    in_total++;
                end
                code = $fscanf(fd, "%d", n_exp);
                if (code != 1 || exp_total + n_exp > max_exp) begin
                    $display("test data record %0d has a bad response count", n_rec);
                    stop_with_failure();
                end
                rec_n_exp[n_rec]   = n_exp;
                rec_exp_ofs[n_rec] = exp_total;
                for (k = 0; k < n_exp; k++) begin
                    code = $fscanf(fd, "%h", byte_exp);
                    exp_bytes[exp_total] = byte_exp;
                    exp_total++;
                end
                n_rec++;
            end
        end
        $fclose(fd);
    endtask

    // holds the byte until the DUT takes it
    task automatic send_byte(input logic [7:0] data, input logic last, input logic user);
        @(negedge clk);
        rx_data_i  = data;
        rx_valid_i = 1'b1;
        rx_last_i  = last;
        rx_user_i  = user;
        @(posedge clk);
        while (!rx_ready_o) begin
            @(posedge clk);
        end
    endtask

    task automatic run_record(input integer idx);
        integer          k;
        logic [11:0]     w;
        logic [byte_w:0] got;
        $display("record %0d: type %c, header %h", idx, rec_kind[idx], rec_hdr[idx]);
        check_value("pending response bytes", rsp_q.size(), 0);
        send_byte(rec_hdr[idx][23:16], 1'b0, 1'b0);
        send_byte(rec_hdr[idx][15:8], 1'b0, 1'b0);
        send_byte(rec_hdr[idx][7:0], 1'b0, 1'b0);
        for (k = 0; k < rec_n_in[idx]; k++) begin
            w = in_words[rec_in_ofs[idx] + k];
            send_byte(w[7:0], w[8], w[9]);
        end
        @(negedge clk);
        rx_valid_i = 1'b0;
        rx_last_i  = 1'b0;
        rx_user_i  = 1'b0;
        rx_data_i  = '0;
        for (k = 0; k < rec_n_exp[idx]; k++) begin
            while (rsp_q.size() == 0) begin
                @(negedge clk);
            end
            got = rsp_q.pop_front();
            check_value($sformatf("tx_data_o (record %0d, byte %0d)", idx, k),
                        got[7:0], exp_bytes[rec_exp_ofs[idx] + k]);
            check_value($sformatf("tx_last_o (record %0d, byte %0d)", idx, k),
                        got[8], (k == rec_n_exp[idx] - 1));
        end
        // nothing may still be going on once the command is over
        check_value("tx_valid_o", tx_valid_o, 0);
        check_value("bus_en_o", bus_en_o, 0);
    endtask

    initial begin
        rst_i      = 1'b1;
        rx_data_i  = '0;
        rx_valid_i = 1'b0;
        rx_last_i  = 1'b0;
        rx_user_i  = 1'b0;
        load_testdata();
        timeout_limit = (n_rec * 3 + in_total + exp_total) * 8 + 500;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst_i = 1'b0;
        // outputs come out of reset quiet
        check_value("rx_ready_o", rx_ready_o, 0);
        check_value("tx_valid_o", tx_valid_o, 0);
        check_value("tx_last_o", tx_last_o, 0);
        check_value("bus_en_o", bus_en_o, 0);
        for (r = 0; r < n_rec; r++) begin
            run_record(r);
        end
        @(negedge clk);
        if (i_boardman_core.i_boardman_assert.fail_cnt == 0 && rsp_q.size() == 0) begin
            $display("All tests passed!");
            $finish;
        end else begin
            $display("response bytes were left over or an assertion failed at the end");
            stop_with_failure();
        end
    end

endmodule

//--- sim/boardman_testdata.txt
# type header n_in in_bytes n_exp exp_bytes (counts decimal, the rest hex)
# in_byte: flag digit (1 last, 2 user) then data; last is expected on the final exp_byte
W 800010 8 011 022 033 044 055 066 077 188 4 80 00 10 08
R 000010 1 107 11 00 00 10 11 22 33 44 55 66 77 88
W c00022 6 0a1 0a2 0a3 0a4 0a5 1a6 4 c0 00 22 06
R 000020 1 107 11 00 00 20 a3 a4 a5 a6 00 00 00 00
W 800011 2 0b1 1b2 4 80 00 11 02
R 000011 1 103 7 00 00 11 b1 b2 44 55
A 800030 3 0c1 2c2 2ff 0
R 000030 1 103 7 00 00 30 00 00 00 00
R 000010 3 003 1ee 1dd 0
R 000010 1 101 5 00 00 10 11 b1

//--- all.f
logic/boardman_pkg.sv
logic/boardman_seq.sv
logic/boardman_addr_track.sv
logic/boardman_word_buf.sv
logic/boardman_tx_mux.sv
logic/boardman_core.sv
sim/tb_reg_target.sv
sim/boardman_assert.sv
sim/tb_boardman.sv
